//--- rtl/csr_pkg.sv
`default_nettype none

package csr_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////
    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [4:0]  ecode_t;
    typedef logic [63:0] counter_t;
    typedef logic [1:0]  event_inc_t;

    // Size of the counter address window
    localparam int MAX_COUNTERS = 8;

    //////////////////////////////////////////////////////////////////////
    // CSR addresses
    //////////////////////////////////////////////////////////////////////
    localparam csr_addr_t MSTATUS     = 12'h300;
    localparam csr_addr_t MTVEC       = 12'h305;
    localparam csr_addr_t MSCRATCH    = 12'h340;
    localparam csr_addr_t MEPC        = 12'h341;
    localparam csr_addr_t MCAUSE      = 12'h342;
    localparam csr_addr_t CNT_LO_BASE = 12'hB00;
    localparam csr_addr_t CNT_HI_BASE = 12'hB80;

    // Legal machine exception codes
    localparam ecode_t EXC_INST_MISALIGNED  = 5'd0;
    localparam ecode_t EXC_ILLEGAL_INST     = 5'd2;
    localparam ecode_t EXC_BREAKPOINT       = 5'd3;
    localparam ecode_t EXC_LOAD_MISALIGNED  = 5'd4;
    localparam ecode_t EXC_STORE_MISALIGNED = 5'd6;
    localparam ecode_t EXC_ECALL_M          = 5'd11;

    //////////////////////////////////////////////////////////////////////
    // Enums and structs
    //////////////////////////////////////////////////////////////////////
    // Encoded like funct3[1:0] of the CSR instructions
    typedef enum logic [1:0] {
        CSR_RW = 2'd1,
        CSR_RS = 2'd2,
        CSR_RC = 2'd3
    } csr_op_t;

    typedef enum logic [1:0] {
        IDLE,
        COMMIT,
        DONE
    } ctrl_state_t;

    typedef struct packed {
        csr_addr_t addr;
        csr_op_t   op;
        xlen_t     data;
    } csr_req_t;

    typedef struct packed {
        logic   valid;
        ecode_t code;
        xlen_t  pc;
    } exception_t;

    // Write committed by the controller
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        xlen_t     value;
    } csr_write_t;

    typedef struct packed {
        logic [23:0] rsvd_hi;
        logic        mpie;
        logic [2:0]  rsvd_mid;
        logic        mie;
        logic [2:0]  rsvd_lo;
    } mstatus_t;

endpackage

`default_nettype wire

//--- rtl/csr_access_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module csr_access_ctrl (
    input  logic                clk,
    input  logic                rst,

    // Issue side
    input  logic                req,
    input  csr_pkg::csr_req_t   req_data,
    output logic                ready,

    // Writeback side
    output logic                done,
    input  logic                ack,
    output csr_pkg::xlen_t      rd,

    // Register file side
    output csr_pkg::csr_addr_t  read_addr,
    input  csr_pkg::xlen_t      read_value,
    output csr_pkg::csr_write_t wr
);

    import csr_pkg::*;

    ctrl_state_t state;
    csr_req_t    req_r;
    logic        accept;
    logic        commit_r;
    logic        writable;
    xlen_t       updated;

    assign ready  = (state == IDLE);
    assign accept = req & ready;

    //////////////////////////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= COMMIT;
                    end
                end
                COMMIT: begin
                    state <= DONE;
                end
                DONE: begin
                    if (done & ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Operand capture
    always_ff @(posedge clk) begin
        if (accept) begin
            req_r <= req_data;
        end
    end

    assign read_addr = req_r.addr;

    //////////////////////////////////////////////////////////////////////
    // Read-modify-write
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (req_r.op)
            CSR_RS:  updated = read_value | req_r.data;
            CSR_RC:  updated = read_value & ~req_r.data;
            default: updated = req_r.data;
        endcase
    end

    // Top two address bits both set marks a read-only CSR
    assign writable = (req_r.addr[11:10] != 2'b11);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr.en    <= 1'b0;
            commit_r <= 1'b0;
        end else begin
            wr.en    <= (state == COMMIT) & writable;
            commit_r <= (state == COMMIT);
        end
    end

    // Old value and write payload
    always_ff @(posedge clk) begin
        if (state == COMMIT) begin
            rd       <= read_value;
            wr.addr  <= req_r.addr;
            wr.value <= updated;
        end
    end

    // Done one edge after the write strobe, held until acked
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= (done & ~ack) | commit_r;
        end
    end

endmodule

`default_nettype wire

//--- rtl/csr_trap_regs.sv
`timescale 1ns/10ps
`default_nettype none

module csr_trap_regs #(
    parameter csr_pkg::xlen_t RESET_MTVEC = 32'h0000_0100
) (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::csr_write_t wr,
    input  csr_pkg::exception_t exception,
    input  logic                mret,
    output csr_pkg::mstatus_t   mstatus,
    output csr_pkg::xlen_t      mtvec,
    output csr_pkg::xlen_t      mepc,
    output csr_pkg::xlen_t      mscratch,
    output csr_pkg::xlen_t      mcause
);

    import csr_pkg::*;

    mstatus_t mstatus_wr;
    mstatus_t mstatus_next;
    ecode_t   mcause_code;
    logic     mcause_legal;

    function automatic logic write_hit(input csr_addr_t addr);
        return wr.en && (wr.addr == addr);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // mstatus
    //////////////////////////////////////////////////////////////////////
    // Only MIE and MPIE are implemented
    always_comb begin
        mstatus_wr      = '0;
        mstatus_wr.mie  = wr.value[3];
        mstatus_wr.mpie = wr.value[7];
    end

    always_comb begin
        mstatus_next = mstatus;
        if (write_hit(MSTATUS)) begin
            mstatus_next = mstatus_wr;
        end else if (exception.valid) begin
            mstatus_next.mpie = mstatus.mie;
            mstatus_next.mie  = 1'b0;
        end else if (mret) begin
            mstatus_next.mie  = mstatus.mpie;
            mstatus_next.mpie = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= '0;
        end else begin
            mstatus <= mstatus_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // mtvec, mepc, mscratch
    //////////////////////////////////////////////////////////////////////
    // Direct mode only
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec <= {RESET_MTVEC[31:2], 2'b00};
        end else if (write_hit(MTVEC)) begin
            mtvec <= {wr.value[31:2], 2'b00};
        end
    end

    // Trap entry wins over a software write
    always_ff @(posedge clk) begin
        if (rst) begin
            mepc <= '0;
        end else if (exception.valid) begin
            mepc <= {exception.pc[31:2], 2'b00};
        end else if (write_hit(MEPC)) begin
            mepc <= {wr.value[31:2], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch <= '0;
        end else if (write_hit(MSCRATCH)) begin
            mscratch <= wr.value;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // mcause
    //////////////////////////////////////////////////////////////////////
    // Interrupt causes are not supported
    assign mcause_legal = ~wr.value[31] && (wr.value[4:0] inside {
        EXC_INST_MISALIGNED, EXC_ILLEGAL_INST, EXC_BREAKPOINT,
        EXC_LOAD_MISALIGNED, EXC_STORE_MISALIGNED, EXC_ECALL_M});

    always_ff @(posedge clk) begin
        if (rst) begin
            mcause_code <= '0;
        end else if (exception.valid) begin
            mcause_code <= exception.code;
        end else if (write_hit(MCAUSE) && mcause_legal) begin
            mcause_code <= wr.value[4:0];
        end
    end

    assign mcause = {27'b0, mcause_code};

endmodule

`default_nettype wire

//--- rtl/csr_event_counter.sv
`timescale 1ns/10ps
`default_nettype none

module csr_event_counter #(
    parameter int INDEX = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_pkg::csr_write_t  wr,
    input  csr_pkg::event_inc_t  event_inc,
    output csr_pkg::counter_t    count
);

    import csr_pkg::*;

    localparam csr_addr_t LO_ADDR = CNT_LO_BASE + csr_addr_t'(INDEX);
    localparam csr_addr_t HI_ADDR = CNT_HI_BASE + csr_addr_t'(INDEX);

    logic     wr_lo;
    logic     wr_hi;
    counter_t count_next;

    assign wr_lo = wr.en && (wr.addr == LO_ADDR);
    assign wr_hi = wr.en && (wr.addr == HI_ADDR);

    // Software write replaces a half and skips this cycle's events
    always_comb begin
        count_next = count;
        if (wr_lo) begin
            count_next[31:0] = wr.value;
        end
        if (wr_hi) begin
            count_next[63:32] = wr.value;
        end
        if (!(wr_lo || wr_hi)) begin
            count_next = count + counter_t'(event_inc);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

endmodule

`default_nettype wire

//--- rtl/csr_read_mux.sv
`timescale 1ns/10ps
`default_nettype none

module csr_read_mux #(
    parameter int NUM_COUNTERS = 2
) (
    input  csr_pkg::csr_addr_t                    addr,
    input  csr_pkg::mstatus_t                     mstatus,
    input  csr_pkg::xlen_t                        mtvec,
    input  csr_pkg::xlen_t                        mepc,
    input  csr_pkg::xlen_t                        mscratch,
    input  csr_pkg::xlen_t                        mcause,
    input  csr_pkg::counter_t [NUM_COUNTERS-1:0]  counts,
    output csr_pkg::xlen_t                        value
);

    import csr_pkg::*;

    // Counter window covers MAX_COUNTERS slots per half
    localparam int IDX_W = $clog2(MAX_COUNTERS);

    logic             in_lo_window;
    logic             in_hi_window;
    logic [IDX_W-1:0] idx;
    xlen_t            counter_value;

    assign idx          = addr[IDX_W-1:0];
    assign in_lo_window = (addr[11:IDX_W] == CNT_LO_BASE[11:IDX_W]);
    assign in_hi_window = (addr[11:IDX_W] == CNT_HI_BASE[11:IDX_W]);

    // Unimplemented slots in the window read zero
    always_comb begin
        counter_value = '0;
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            if (idx == IDX_W'(i)) begin
                if (in_lo_window) begin
                    counter_value = counts[i][31:0];
                end else if (in_hi_window) begin
                    counter_value = counts[i][63:32];
                end
            end
        end
    end

    always_comb begin
        case (addr)
            MSTATUS:  value = xlen_t'(mstatus);
            MTVEC:    value = mtvec;
            MSCRATCH: value = mscratch;
            MEPC:     value = mepc;
            MCAUSE:   value = mcause;
            default:  value = counter_value;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit #(
    parameter int             NUM_COUNTERS = 2,
    parameter csr_pkg::xlen_t RESET_MTVEC  = 32'h0000_0100
) (
    input  logic                                   clk,
    input  logic                                   rst,

    // Issue and writeback
    input  logic                                   req,
    input  csr_pkg::csr_req_t                      req_data,
    output logic                                   ready,
    output logic                                   done,
    input  logic                                   ack,
    output csr_pkg::xlen_t                         rd,

    // Trap control
    input  csr_pkg::exception_t                    exception,
    input  logic                                   mret,
    input  csr_pkg::event_inc_t [NUM_COUNTERS-1:0] events,
    output csr_pkg::xlen_t                         trap_target,
    output csr_pkg::xlen_t                         epc
);

    import csr_pkg::*;

    csr_write_t                   wr;
    csr_addr_t                    read_addr;
    xlen_t                        read_value;
    mstatus_t                     mstatus;
    xlen_t                        mtvec;
    xlen_t                        mepc;
    xlen_t                        mscratch;
    xlen_t                        mcause;
    counter_t [NUM_COUNTERS-1:0]  counts;

    csr_access_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_data   (req_data),
        .ready      (ready),
        .done       (done),
        .ack        (ack),
        .rd         (rd),
        .read_addr  (read_addr),
        .read_value (read_value),
        .wr         (wr)
    );

    csr_trap_regs #(
        .RESET_MTVEC (RESET_MTVEC)
    ) u_trap_regs (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .exception (exception),
        .mret      (mret),
        .mstatus   (mstatus),
        .mtvec     (mtvec),
        .mepc      (mepc),
        .mscratch  (mscratch),
        .mcause    (mcause)
    );

    //////////////////////////////////////////////////////////////////////
    // Event counter bank
    //////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < NUM_COUNTERS; i++) begin : gen_counter
        csr_event_counter #(
            .INDEX (i)
        ) u_counter (
            .clk       (clk),
            .rst       (rst),
            .wr        (wr),
            .event_inc (events[i]),
            .count     (counts[i])
        );
    end

    csr_read_mux #(
        .NUM_COUNTERS (NUM_COUNTERS)
    ) u_read_mux (
        .addr     (read_addr),
        .mstatus  (mstatus),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .mscratch (mscratch),
        .mcause   (mcause),
        .counts   (counts),
        .value    (read_value)
    );

    assign trap_target = mtvec;
    assign epc         = mepc;

endmodule

`default_nettype wire

//--- sim/csr_unit_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit_asserts (
    input logic           clk,
    input logic           rst,
    input logic           req,
    input logic           ready,
    input logic           done,
    input logic           ack,
    input csr_pkg::xlen_t rd
);

    // Writeback stays up with a stable value until acknowledged
    property done_held_until_ack;
        @(posedge clk) disable iff (rst)
        done && !ack |=> done && $stable(rd);
    endproperty

    // No new issue while a writeback is pending
    property ready_low_while_done;
        @(posedge clk) disable iff (rst)
        done |-> !ready;
    endproperty

    // Done rises at the second edge after acceptance
    property done_two_edges_after_accept;
        @(posedge clk) disable iff (rst)
        req && ready |-> ##3 $rose(done);
    endproperty

    assert property (done_held_until_ack)
        else $error("done dropped or rd changed before ack");
    assert property (ready_low_while_done)
        else $error("ready high while done is pending");
    assert property (done_two_edges_after_accept)
        else $error("done did not rise two edges after acceptance");

endmodule

bind csr_unit csr_unit_asserts u_asserts (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .ready (ready),
    .done  (done),
    .ack   (ack),
    .rd    (rd)
);

`default_nettype wire

//--- sim/csr_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit_tb;

    import csr_pkg::*;

    localparam int    NUM_COUNTERS    = 2;
    localparam xlen_t RESET_MTVEC     = 32'h0000_0A40;
    localparam int    CLK_PERIOD      = 40;
    localparam int    DRIVE_DELAY     = 2;
    localparam int    RESET_CYCLES    = 16;
    localparam int    NUM_TESTS       = 6;
    localparam int    TEST_CYCLES     = 200;
    localparam int    TIMEOUT_CYCLES  = RESET_CYCLES + NUM_TESTS * TEST_CYCLES;
    localparam int    WAIT_LIMIT      = 16;
    localparam int    EVENT_CYCLES    = 10;
    localparam int    EVENT_INC       = 3;
    localparam int    HOLD_CYCLES     = 8;
    localparam xlen_t SEED            = 32'he2c0_462f;

    // mstatus bit positions from the privileged spec
    localparam xlen_t MIE_BIT  = 32'h0000_0008;
    localparam xlen_t MPIE_BIT = 32'h0000_0080;

    logic                          clk;
    logic                          rst;
    logic                          req;
    csr_req_t                      req_data;
    logic                          ready;
    logic                          done;
    logic                          ack;
    xlen_t                         rd;
    exception_t                    exception;
    logic                          mret;
    event_inc_t [NUM_COUNTERS-1:0] events;
    xlen_t                         trap_target;
    xlen_t                         epc;

    xlen_t rng_state;
    xlen_t scratch_model;

    csr_unit #(
        .NUM_COUNTERS (NUM_COUNTERS),
        .RESET_MTVEC  (RESET_MTVEC)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .req_data    (req_data),
        .ready       (ready),
        .done        (done),
        .ack         (ack),
        .rd          (rd),
        .exception   (exception),
        .mret        (mret),
        .events      (events),
        .trap_target (trap_target),
        .epc         (epc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
        stop_run();
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    function automatic xlen_t xorshift_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic next_edge();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Holds req until an edge with ready high
    task automatic send_request(input csr_addr_t addr, input csr_op_t op, input xlen_t data);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        req           = 1'b1;
        req_data.addr = addr;
        req_data.op   = op;
        req_data.data = data;
        while (!taken) begin
            taken = ready;
            next_edge();
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Request to address %h was never accepted", addr);
                stop_run();
            end
        end
        req = 1'b0;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (!done) begin
            next_edge();
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("done never rose after an accepted request");
                stop_run();
            end
        end
    endtask

    task automatic ack_writeback();
        ack = 1'b1;
        next_edge();
        ack = 1'b0;
        check_value("done after ack", 32'd0, xlen_t'(done));
    endtask

    task automatic csr_access(input csr_addr_t addr, input csr_op_t op, input xlen_t data,
                              input xlen_t expected, input string name);
        send_request(addr, op, data);
        wait_done();
        check_value(name, expected, rd);
        ack_writeback();
    endtask

    // Set with a zero operand reads without changing the value
    task automatic read_csr(input csr_addr_t addr, input xlen_t expected, input string name);
        csr_access(addr, CSR_RS, 32'd0, expected, name);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic reset_values();
        read_csr(MTVEC, RESET_MTVEC, "mtvec");
        read_csr(MSTATUS, 32'd0, "mstatus");
        read_csr(MEPC, 32'd0, "mepc");
        read_csr(MSCRATCH, 32'd0, "mscratch");
        read_csr(MCAUSE, 32'd0, "mcause");
        check_value("trap_target", RESET_MTVEC, trap_target);
    endtask

    task automatic scratch_rmw();
        xlen_t operand;
        operand = xorshift_next();
        csr_access(MSCRATCH, CSR_RW, operand, scratch_model, "mscratch rw old");
        scratch_model = operand;
        read_csr(MSCRATCH, scratch_model, "mscratch after rw");
        operand = xorshift_next();
        csr_access(MSCRATCH, CSR_RS, operand, scratch_model, "mscratch rs old");
        scratch_model = scratch_model | operand;
        read_csr(MSCRATCH, scratch_model, "mscratch after rs");
        operand = xorshift_next();
        csr_access(MSCRATCH, CSR_RC, operand, scratch_model, "mscratch rc old");
        scratch_model = scratch_model & ~operand;
        read_csr(MSCRATCH, scratch_model, "mscratch after rc");
    endtask

    task automatic masking_and_legality();
        csr_access(MTVEC, CSR_RW, '1, RESET_MTVEC, "mtvec old");
        read_csr(MTVEC, 32'hFFFF_FFFC, "mtvec masked");
        check_value("trap_target", 32'hFFFF_FFFC, trap_target);
        csr_access(MSTATUS, CSR_RW, '1, 32'd0, "mstatus old");
        read_csr(MSTATUS, MIE_BIT | MPIE_BIT, "mstatus masked");
        csr_access(MCAUSE, CSR_RW, 32'd11, 32'd0, "mcause old");
        read_csr(MCAUSE, 32'd11, "mcause legal code");
        csr_access(MCAUSE, CSR_RW, 32'd5, 32'd11, "mcause old");
        read_csr(MCAUSE, 32'd11, "mcause after code 5");
        csr_access(MCAUSE, CSR_RW, 32'h8000_0002, 32'd11, "mcause old");
        read_csr(MCAUSE, 32'd11, "mcause after interrupt bit");
        // Read-only and unmapped, so it reads zero and changes nothing
        csr_access(12'hC00, CSR_RW, xorshift_next(), 32'd0, "read-only old");
        read_csr(12'hC00, 32'd0, "read-only after write");
        read_csr(MSCRATCH, scratch_model, "mscratch after read-only write");
        read_csr(MTVEC, 32'hFFFF_FFFC, "mtvec after read-only write");
    endtask

    task automatic trap_entry_return();
        csr_access(MSTATUS, CSR_RW, 32'd0, MIE_BIT | MPIE_BIT, "mstatus old");
        csr_access(MSTATUS, CSR_RS, MIE_BIT, 32'd0, "mstatus set old");
        read_csr(MSTATUS, MIE_BIT, "mstatus with mie");
        exception.valid = 1'b1;
        exception.code  = EXC_ILLEGAL_INST;
        exception.pc    = 32'h0000_1236;
        next_edge();
        exception = '0;
        check_value("epc", 32'h0000_1234, epc);
        read_csr(MCAUSE, 32'd2, "mcause after trap");
        read_csr(MEPC, 32'h0000_1234, "mepc after trap");
        read_csr(MSTATUS, MPIE_BIT, "mstatus after trap");
        mret = 1'b1;
        next_edge();
        mret = 1'b0;
        read_csr(MSTATUS, MIE_BIT | MPIE_BIT, "mstatus after mret");
    endtask

    task automatic event_counters();
        csr_addr_t lo_addr;
        csr_addr_t hi_addr;
        counter_t  cnt_model;
        lo_addr = CNT_LO_BASE + 12'd1;
        hi_addr = CNT_HI_BASE + 12'd1;
        events  = '0;
        csr_access(lo_addr, CSR_RW, 32'hFFFF_FFF0, 32'd0, "counter1 lo old");
        csr_access(hi_addr, CSR_RW, 32'd5, 32'd0, "counter1 hi old");
        read_csr(lo_addr, 32'hFFFF_FFF0, "counter1 lo written");
        read_csr(hi_addr, 32'd5, "counter1 hi written");
        cnt_model = {32'd5, 32'hFFFF_FFF0} + counter_t'(EVENT_CYCLES * EVENT_INC);
        events[1] = event_inc_t'(EVENT_INC);
        repeat (EVENT_CYCLES) next_edge();
        events = '0;
        read_csr(lo_addr, cnt_model[31:0], "counter1 lo counted");
        read_csr(hi_addr, cnt_model[63:32], "counter1 hi counted");
        read_csr(CNT_LO_BASE, 32'd0, "counter0 lo");
        read_csr(CNT_HI_BASE, 32'd0, "counter0 hi");
        read_csr(CNT_LO_BASE + csr_addr_t'(NUM_COUNTERS), 32'd0, "out-of-range lo");
        read_csr(CNT_HI_BASE + csr_addr_t'(NUM_COUNTERS), 32'd0, "out-of-range hi");
    endtask

    task automatic back_pressure();
        xlen_t operand;
        xlen_t held_rd;
        operand = xorshift_next();
        send_request(MSCRATCH, CSR_RW, operand);
        wait_done();
        check_value("rd before ack", scratch_model, rd);
        held_rd = rd;
        // Second request waits while ack stays low
        req           = 1'b1;
        req_data.addr = MSCRATCH;
        req_data.op   = CSR_RS;
        req_data.data = 32'd0;
        repeat (HOLD_CYCLES) begin
            next_edge();
            check_value("done while stalled", 32'd1, xlen_t'(done));
            check_value("ready while stalled", 32'd0, xlen_t'(ready));
            check_value("rd while stalled", held_rd, rd);
        end
        ack = 1'b1;
        next_edge();
        ack = 1'b0;
        check_value("ready after ack", 32'd1, xlen_t'(ready));
        next_edge();
        req = 1'b0;
        check_value("ready after second accept", 32'd0, xlen_t'(ready));
        wait_done();
        scratch_model = operand;
        check_value("rd of second request", scratch_model, rd);
        ack_writeback();
    endtask

    initial begin
        rst           = 1'b1;
        req           = 1'b0;
        req_data      = '0;
        ack           = 1'b0;
        exception     = '0;
        mret          = 1'b0;
        events        = '0;
        rng_state     = SEED;
        scratch_model = 32'd0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        check_value("ready after reset", 32'd1, xlen_t'(ready));
        check_value("done after reset", 32'd0, xlen_t'(done));

        reset_values();
        scratch_rmw();
        masking_and_legality();
        trap_entry_return();
        event_counters();
        back_pressure();

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
rtl/csr_pkg.sv
rtl/csr_access_ctrl.sv
rtl/csr_trap_regs.sv
rtl/csr_event_counter.sv
rtl/csr_read_mux.sv
rtl/csr_unit.sv
sim/csr_unit_asserts.sv
sim/csr_unit_tb.sv

//--- Makefile
# Verilator build and run for the CSR unit testbench

VERILATOR   ?= verilator
TOP         ?= csr_unit_tb
FILELIST    ?= filelist.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= --lint-only --timing --assert
PASS_MSG    ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass message shows up as a line of its own
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
